// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run tb_sig_check and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --assert --timing --timescale 1ns/1ps -j 0 \
		--top-module tb_sig_check -f sig_check_top.f -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q -F "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: secp256k1_pkg.sv
package secp256k1_pkg;

  // Scalar and field elements are 256 bits wide
  localparam int SCALAR_BITS = 256;

  // A scalar arrives over the command stream in 64-bit words
  localparam int WORD_BITS = 64;
  localparam int SCALAR_WORDS = SCALAR_BITS / WORD_BITS;

  typedef logic [SCALAR_BITS-1:0] scalar_t;

  // Group order n of the curve
  localparam scalar_t CURVE_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

endpackage

// File: sig_check_fsm.sv
`timescale 1ns/1ps

module sig_check_fsm (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  sig_cmd_pkg::stream_beat_t i_cmd,
  input  logic                      i_cmd_val,
  output logic                      o_cmd_rdy,
  output logic                      o_cap_we,
  output sig_cmd_pkg::beat_idx_t    o_beat,
  output logic                      o_busy,
  input  logic                      i_expired,
  output logic                      o_rpl_start,
  output logic                      o_timeout,
  input  logic                      i_rpl_done
);

  sig_cmd_pkg::chk_state_t state;
  sig_cmd_pkg::chk_state_t state_nxt;
  sig_cmd_pkg::cmd_hdr_t   hdr;
  sig_cmd_pkg::beat_idx_t  beat_cnt;
  logic                    take;
  logic                    last_beat;

  always_comb begin
    hdr       = sig_cmd_pkg::cmd_hdr_t'(i_cmd.dat);
    take      = i_cmd_val && o_cmd_rdy;
    last_beat = (beat_cnt == sig_cmd_pkg::beat_idx_t'(sig_cmd_pkg::CMD_BEATS - 1));
    o_cap_we  = take && (state == sig_cmd_pkg::PARSE);
    o_beat    = beat_cnt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      sig_cmd_pkg::IDLE: begin
        if (take) begin
          if (hdr.cmd == sig_cmd_pkg::VERIFY_SIG) begin
            state_nxt = sig_cmd_pkg::PARSE;
          end else if (!i_cmd.eop) begin
            state_nxt = sig_cmd_pkg::IGNORE;
          end
        end
      end
      sig_cmd_pkg::PARSE: begin
        // A completed command wins over a watchdog expiring in the same cycle
        if ((take && last_beat) || i_expired) begin
          state_nxt = sig_cmd_pkg::REPLY;
        end
      end
      sig_cmd_pkg::REPLY: begin
        if (i_rpl_done) begin
          state_nxt = o_timeout ? sig_cmd_pkg::DRAIN : sig_cmd_pkg::IDLE;
        end
      end
      sig_cmd_pkg::DRAIN, sig_cmd_pkg::IGNORE: begin
        if (take && i_cmd.eop) begin
          state_nxt = sig_cmd_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = sig_cmd_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= sig_cmd_pkg::IDLE;
      beat_cnt    <= '0;
      o_cmd_rdy   <= 1'b0;
      o_busy      <= 1'b0;
      o_rpl_start <= 1'b0;
      o_timeout   <= 1'b0;
    end else begin
      state       <= state_nxt;
      o_cmd_rdy   <= (state_nxt != sig_cmd_pkg::REPLY);
      o_busy      <= (state_nxt == sig_cmd_pkg::PARSE);
      o_rpl_start <= (state == sig_cmd_pkg::PARSE) && (state_nxt == sig_cmd_pkg::REPLY);

      // Next expected position is the index beat after the header
      if (state == sig_cmd_pkg::IDLE) begin
        beat_cnt <= sig_cmd_pkg::beat_idx_t'(sig_cmd_pkg::BEAT_IDX_POS);
      end else if (o_cap_we) begin
        beat_cnt <= beat_cnt + 1'b1;
      end

      if ((state == sig_cmd_pkg::PARSE) && (state_nxt == sig_cmd_pkg::REPLY)) begin
        o_timeout <= !(take && last_beat);
      end
    end
  end

endmodule

// File: sig_check_top.f
secp256k1_pkg.sv
sig_cmd_pkg.sv
sig_field_capture.sv
sig_watchdog.sv
sig_reply_tx.sv
sig_check_fsm.sv
sig_check_top.sv
tb_clk_gen.sv
tb_sig_check.sv

// File: sig_check_top.sv
`timescale 1ns/1ps

module sig_check_top (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  sig_cmd_pkg::stream_beat_t i_cmd,
  input  logic                      i_cmd_val,
  output logic                      o_cmd_rdy,
  output sig_cmd_pkg::stream_beat_t o_rpl,
  output logic                      o_rpl_val,
  input  logic                      i_rpl_rdy
);

  sig_cmd_pkg::beat_idx_t   beat;
  sig_cmd_pkg::beat_dat_t   index;
  sig_cmd_pkg::sig_status_t range;
  sig_cmd_pkg::sig_status_t status;
  logic                     cap_we;
  logic                     busy;
  logic                     expired;
  logic                     rpl_start;
  logic                     timeout;
  logic                     rpl_done;

  // Range flags mean nothing for a partly received command
  always_comb begin
    status                = '0;
    status.out_of_range_s = range.out_of_range_s && !timeout;
    status.out_of_range_r = range.out_of_range_r && !timeout;
    status.timeout_fail   = timeout;
  end

  sig_check_fsm u_fsm (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_cmd       (i_cmd),
    .i_cmd_val   (i_cmd_val),
    .o_cmd_rdy   (o_cmd_rdy),
    .o_cap_we    (cap_we),
    .o_beat      (beat),
    .o_busy      (busy),
    .i_expired   (expired),
    .o_rpl_start (rpl_start),
    .o_timeout   (timeout),
    .i_rpl_done  (rpl_done)
  );

  sig_watchdog u_watchdog (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_run     (busy),
    .o_expired (expired)
  );

  sig_field_capture u_capture (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_cmd_dat (i_cmd.dat),
    .i_we      (cap_we),
    .i_beat    (beat),
    .o_index   (index),
    .o_range   (range)
  );

  sig_reply_tx u_reply_tx (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_start   (rpl_start),
    .i_index   (index),
    .i_status  (status),
    .o_rpl     (o_rpl),
    .o_rpl_val (o_rpl_val),
    .i_rpl_rdy (i_rpl_rdy),
    .o_done    (rpl_done)
  );

endmodule

// File: sig_cmd_pkg.sv
package sig_cmd_pkg;

  typedef logic [63:0] beat_dat_t;

  // Valid bytes in the last beat, 0 means all eight
  typedef logic [2:0] beat_mod_t;

  typedef struct packed {
    beat_dat_t dat;
    logic      sop;
    logic      eop;
    beat_mod_t mod;
  } stream_beat_t;

  typedef enum logic [15:0] {
    VERIFY_SIG     = 16'h0101,
    VERIFY_SIG_RPL = 16'h0201
  } cmd_code_t;

  typedef logic [15:0] cmd_len_t;

  typedef struct packed {
    cmd_code_t   cmd;
    cmd_len_t    len;
    logic [31:0] rsvd;
  } cmd_hdr_t;

  typedef logic [4:0] beat_idx_t;

  // Verify command layout, header at beat 0, scalars least significant word first
  localparam int CMD_BEATS = 22;
  localparam int BEAT_IDX_POS = 1;
  localparam int BEAT_S_POS = 2;
  localparam int BEAT_R_POS = 6;

  typedef struct packed {
    logic [4:0] spare;
    logic       timeout_fail;
    logic       out_of_range_r;
    logic       out_of_range_s;
  } sig_status_t;

  localparam int RPL_BEATS = 3;

  localparam int WDOG_CYCLES = 1024;
  typedef logic [10:0] wdog_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    PARSE,
    REPLY,
    DRAIN,
    IGNORE
  } chk_state_t;

endpackage

// File: sig_field_capture.sv
`timescale 1ns/1ps

module sig_field_capture (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  sig_cmd_pkg::beat_dat_t   i_cmd_dat,
  input  logic                     i_we,
  input  sig_cmd_pkg::beat_idx_t   i_beat,
  output sig_cmd_pkg::beat_dat_t   o_index,
  output sig_cmd_pkg::sig_status_t o_range
);

  localparam int SEL_W = $clog2(secp256k1_pkg::SCALAR_WORDS);
  localparam int S_LAST = sig_cmd_pkg::BEAT_S_POS + secp256k1_pkg::SCALAR_WORDS - 1;
  localparam int R_LAST = sig_cmd_pkg::BEAT_R_POS + secp256k1_pkg::SCALAR_WORDS - 1;

  secp256k1_pkg::scalar_t s_q;
  secp256k1_pkg::scalar_t r_q;
  logic [SEL_W-1:0]       s_sel;
  logic [SEL_W-1:0]       r_sel;
  logic                   s_hit;
  logic                   r_hit;
  logic                   idx_hit;

  // Beat position to target field and word within it
  always_comb begin
    idx_hit = (i_beat == sig_cmd_pkg::beat_idx_t'(sig_cmd_pkg::BEAT_IDX_POS));
    s_hit   = (i_beat >= sig_cmd_pkg::beat_idx_t'(sig_cmd_pkg::BEAT_S_POS)) &&
              (i_beat <= sig_cmd_pkg::beat_idx_t'(S_LAST));
    r_hit   = (i_beat >= sig_cmd_pkg::beat_idx_t'(sig_cmd_pkg::BEAT_R_POS)) &&
              (i_beat <= sig_cmd_pkg::beat_idx_t'(R_LAST));
    s_sel   = SEL_W'(i_beat - sig_cmd_pkg::beat_idx_t'(sig_cmd_pkg::BEAT_S_POS));
    r_sel   = SEL_W'(i_beat - sig_cmd_pkg::beat_idx_t'(sig_cmd_pkg::BEAT_R_POS));
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_index <= '0;
      s_q     <= '0;
      r_q     <= '0;
    end else if (i_we) begin
      if (idx_hit) begin
        o_index <= i_cmd_dat;
      end
      if (s_hit) begin
        s_q[s_sel*secp256k1_pkg::WORD_BITS +: secp256k1_pkg::WORD_BITS] <= i_cmd_dat;
      end
      if (r_hit) begin
        r_q[r_sel*secp256k1_pkg::WORD_BITS +: secp256k1_pkg::WORD_BITS] <= i_cmd_dat;
      end
    end
  end

  // Out of range at n and above
  always_comb begin
    o_range                = '0;
    o_range.out_of_range_s = (s_q >= secp256k1_pkg::CURVE_N);
    o_range.out_of_range_r = (r_q >= secp256k1_pkg::CURVE_N);
  end

endmodule

// File: sig_reply_tx.sv
`timescale 1ns/1ps

module sig_reply_tx (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_start,
  input  sig_cmd_pkg::beat_dat_t    i_index,
  input  sig_cmd_pkg::sig_status_t  i_status,
  output sig_cmd_pkg::stream_beat_t o_rpl,
  output logic                      o_rpl_val,
  input  logic                      i_rpl_rdy,
  output logic                      o_done
);

  localparam int CNT_W = $clog2(sig_cmd_pkg::RPL_BEATS);

  logic [CNT_W-1:0]         beat_cnt;
  logic                     last;
  sig_cmd_pkg::beat_dat_t   index_q;
  sig_cmd_pkg::sig_status_t status_q;
  sig_cmd_pkg::cmd_hdr_t    hdr;

  // Beat contents come from latched values so they hold under back-pressure
  always_comb begin
    hdr     = '0;
    hdr.cmd = sig_cmd_pkg::VERIFY_SIG_RPL;
    hdr.len = sig_cmd_pkg::cmd_len_t'(sig_cmd_pkg::RPL_BEATS);
    last    = (beat_cnt == CNT_W'(sig_cmd_pkg::RPL_BEATS - 1));
    o_done  = o_rpl_val && i_rpl_rdy && last;

    o_rpl = '0;
    if (beat_cnt == '0) begin
      o_rpl.dat = hdr;
      o_rpl.sop = 1'b1;
    end else if (last) begin
      // Status in the low byte, full last beat
      o_rpl.dat = sig_cmd_pkg::beat_dat_t'(status_q);
      o_rpl.eop = 1'b1;
    end else begin
      o_rpl.dat = index_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      index_q  <= i_index;
      status_q <= i_status;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rpl_val <= 1'b0;
      beat_cnt  <= '0;
    end else if (i_start) begin
      o_rpl_val <= 1'b1;
      beat_cnt  <= '0;
    end else if (o_rpl_val && i_rpl_rdy) begin
      if (last) begin
        o_rpl_val <= 1'b0;
        beat_cnt  <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

// File: sig_watchdog.sv
`timescale 1ns/1ps

module sig_watchdog (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_run,
  output logic o_expired
);

  sig_cmd_pkg::wdog_cnt_t cnt;

  // Restarts whenever the command leaves the parse phase
  always_ff @(posedge i_clk) begin
    if (i_rst || !i_run) begin
      cnt <= '0;
    end else if (!o_expired) begin
      cnt <= cnt + 1'b1;
    end
  end

  // Holds at the limit until i_run drops
  assign o_expired = (cnt == sig_cmd_pkg::wdog_cnt_t'(sig_cmd_pkg::WDOG_CYCLES));

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst
);

  localparam int HALF_PERIOD_NS = 50;
  localparam int RST_CYCLES = 10;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
  end

  // Reset drops on a rising edge so the DUT leaves it synchronously
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

// File: tb_sig_check.sv
`timescale 1ns/1ps

module tb_sig_check;

  // Group order n of secp256k1
  localparam secp256k1_pkg::scalar_t N_REF =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;
  localparam int S_BEAT = 2;
  localparam int R_BEAT = 6;
  localparam int HASH_BEAT = 10;
  localparam int RPL_WAIT = 200;

  logic                      i_clk;
  logic                      i_rst;
  sig_cmd_pkg::stream_beat_t i_cmd;
  logic                      i_cmd_val;
  logic                      o_cmd_rdy;
  sig_cmd_pkg::stream_beat_t o_rpl;
  logic                      o_rpl_val;
  logic                      i_rpl_rdy;

  sig_cmd_pkg::beat_dat_t    cmd_buf [0:31];
  sig_cmd_pkg::stream_beat_t rpl_q [$];
  sig_cmd_pkg::stream_beat_t held_beat;
  logic                      stalled;
  logic                      bp_en;
  int                        cmd_cnt = 0;
  int                        cycle_cnt = 0;
  int                        test_cnt = 0;
  int                        check_cnt = 0;
  int                        err_cnt = 0;
  int                        mon_err = 0;
  int                        overlap_err = 0;
  int                        reset_err = 0;
  int                        wake_err = 0;

  tb_clk_gen u_clk_gen (
    .o_clk (i_clk),
    .o_rst (i_rst)
  );

  sig_check_top i_sig_check_top (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_cmd     (i_cmd),
    .i_cmd_val (i_cmd_val),
    .o_cmd_rdy (o_cmd_rdy),
    .o_rpl     (o_rpl),
    .o_rpl_val (o_rpl_val),
    .i_rpl_rdy (i_rpl_rdy)
  );

  // Command input stays closed while a reply is going out
  assert property (@(posedge i_clk) disable iff (i_rst) o_rpl_val |-> !o_cmd_rdy)
    else begin
      overlap_err++;
      $display("Fail %0t o_cmd_rdy expected 0 got 1", $time);
    end

  assert property (@(posedge i_clk) $past(i_rst) |-> !(o_cmd_rdy || o_rpl_val))
    else begin
      reset_err++;
      $display("Fail %0t o_cmd_rdy|o_rpl_val expected 0 got 1", $time);
    end

  // Ready comes up in the first cycle after reset
  assert property (@(posedge i_clk) ($past(i_rst, 2) && !$past(i_rst)) |-> o_cmd_rdy)
    else begin
      wake_err++;
      $display("Fail %0t o_cmd_rdy expected 1 got 0", $time);
    end

  function automatic int total_errors();
    return err_cnt + mon_err + overlap_err + reset_err + wake_err;
  endfunction

  function automatic sig_cmd_pkg::beat_dat_t rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic secp256k1_pkg::scalar_t below_n();
    secp256k1_pkg::scalar_t v;
    v = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
    if (v >= N_REF) begin
      v = v - N_REF;
    end
    return v;
  endfunction

  function automatic secp256k1_pkg::scalar_t above_n();
    return N_REF + 256'({$urandom, $urandom}) + 256'd1;
  endfunction

  // Reply status as the command rules define it
  function automatic sig_cmd_pkg::sig_status_t expect_status(input secp256k1_pkg::scalar_t s,
                                                             input secp256k1_pkg::scalar_t r,
                                                             input logic timed_out);
    sig_cmd_pkg::sig_status_t st;
    st = '0;
    if (timed_out) begin
      st.timeout_fail = 1'b1;
    end else begin
      st.out_of_range_s = (s >= N_REF);
      st.out_of_range_r = (r >= N_REF);
    end
    return st;
  endfunction

  function automatic logic [63:0] frame_of(input sig_cmd_pkg::stream_beat_t b);
    return {59'h0, b.sop, b.eop, b.mod};
  endfunction

  task automatic check_word(input string sig, input logic [63:0] exp, input logic [63:0] got);
    check_cnt++;
    assert (got === exp)
      else begin
        err_cnt++;
        $display("Fail %0t %s expected %h got %h", $time, sig, exp, got);
      end
  endtask

  task automatic load_verify(input sig_cmd_pkg::beat_dat_t idx,
                             input secp256k1_pkg::scalar_t s,
                             input secp256k1_pkg::scalar_t r);
    sig_cmd_pkg::cmd_hdr_t hdr;
    int k;
    hdr = '0;
    hdr.cmd = sig_cmd_pkg::VERIFY_SIG;
    hdr.len = 16'(sig_cmd_pkg::CMD_BEATS);
    cmd_buf[0] = hdr;
    cmd_buf[1] = idx;
    // Scalars go least significant word first
    for (k = 0; k < secp256k1_pkg::SCALAR_WORDS; k++) begin
      cmd_buf[S_BEAT + k] = s[k*64 +: 64];
      cmd_buf[R_BEAT + k] = r[k*64 +: 64];
    end
    for (k = HASH_BEAT; k < sig_cmd_pkg::CMD_BEATS; k++) begin
      cmd_buf[k] = rand64();
    end
  endtask

  task automatic load_unknown(input logic [15:0] code, input int n_beats);
    int k;
    cmd_buf[0] = {code, 16'(n_beats), 32'h0};
    for (k = 1; k < n_beats; k++) begin
      cmd_buf[k] = rand64();
    end
  endtask

  // Sends cmd_buf with valid dropped for gap_len cycles before beat gap_at
  task automatic send_cmd(input int n_beats, input int gap_at, input int gap_len);
    sig_cmd_pkg::stream_beat_t b;
    int i;
    cmd_cnt++;
    @(posedge i_clk);
    for (i = 0; i < n_beats; i++) begin
      if (i == gap_at) begin
        i_cmd_val <= 1'b0;
        repeat (gap_len) @(posedge i_clk);
      end
      b = '0;
      b.dat = cmd_buf[i];
      b.sop = (i == 0);
      b.eop = (i == n_beats - 1);
      i_cmd <= b;
      i_cmd_val <= 1'b1;
      do @(negedge i_clk); while (!o_cmd_rdy);
      @(posedge i_clk);
    end
    i_cmd_val <= 1'b0;
  endtask

  task automatic check_reply(input sig_cmd_pkg::beat_dat_t idx,
                             input sig_cmd_pkg::sig_status_t st,
                             input string tag);
    sig_cmd_pkg::cmd_hdr_t     hdr;
    sig_cmd_pkg::stream_beat_t b0;
    sig_cmd_pkg::stream_beat_t b1;
    sig_cmd_pkg::stream_beat_t b2;
    int waited;
    hdr = '0;
    hdr.cmd = sig_cmd_pkg::VERIFY_SIG_RPL;
    hdr.len = 16'(sig_cmd_pkg::RPL_BEATS);
    waited = 0;
    while ((rpl_q.size() < sig_cmd_pkg::RPL_BEATS) && (waited < RPL_WAIT)) begin
      @(posedge i_clk);
      waited++;
    end
    if (rpl_q.size() < sig_cmd_pkg::RPL_BEATS) begin
      err_cnt++;
      $display("%s: no complete reply within %0d cycles", tag, RPL_WAIT);
    end else begin
      b0 = rpl_q.pop_front();
      b1 = rpl_q.pop_front();
      b2 = rpl_q.pop_front();
      check_word("o_rpl.dat beat 0", hdr, b0.dat);
      check_word("o_rpl sop,eop,mod beat 0", 64'h10, frame_of(b0));
      check_word("o_rpl.dat beat 1", idx, b1.dat);
      check_word("o_rpl sop,eop,mod beat 1", 64'h0, frame_of(b1));
      check_word("o_rpl.dat beat 2", {56'h0, st}, b2.dat);
      check_word("o_rpl sop,eop,mod beat 2", 64'h8, frame_of(b2));
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) @(posedge i_clk);
    check_word("reply beat count", 64'd0, 64'(rpl_q.size()));
  endtask

  task automatic verify_once(input secp256k1_pkg::scalar_t s, input secp256k1_pkg::scalar_t r);
    sig_cmd_pkg::beat_dat_t idx;
    int gap_at;
    int gap_len;
    idx = rand64();
    gap_at = $urandom_range(sig_cmd_pkg::CMD_BEATS - 1, 1);
    gap_len = $urandom_range(3, 0);
    load_verify(idx, s, r);
    send_cmd(sig_cmd_pkg::CMD_BEATS, gap_at, gap_len);
    check_reply(idx, expect_status(s, r, 1'b0), "verify");
  endtask

  task automatic finish_test(input string name, input int err_before);
    test_cnt++;
    $display("Test %0d %s finished, %0d errors", test_cnt, name, total_errors() - err_before);
  endtask

  task automatic test_valid();
    int e;
    e = total_errors();
    repeat (4) verify_once(below_n(), below_n());
    verify_once(N_REF - 1, N_REF - 1);
    finish_test("valid signature", e);
  endtask

  task automatic test_range();
    int e;
    e = total_errors();
    verify_once(N_REF, below_n());
    verify_once(below_n(), N_REF);
    verify_once(N_REF, N_REF);
    verify_once('1, below_n());
    verify_once(below_n(), '1);
    verify_once(above_n(), below_n());
    verify_once(below_n(), above_n());
    verify_once(above_n(), above_n());
    finish_test("range flags", e);
  endtask

  task automatic test_unknown();
    int e;
    e = total_errors();
    load_unknown(16'h07a5, 7);
    send_cmd(7, 3, 2);
    // One-beat command last, directly ahead of the verify command
    load_unknown(16'h0333, 1);
    send_cmd(1, -1, 0);
    expect_quiet(20);
    verify_once(below_n(), above_n());
    finish_test("unknown command", e);
  endtask

  // Two commands back to back so the second waits behind the first reply
  task automatic test_backpressure();
    sig_cmd_pkg::beat_dat_t   idx_a;
    sig_cmd_pkg::beat_dat_t   idx_b;
    sig_cmd_pkg::sig_status_t st_a;
    sig_cmd_pkg::sig_status_t st_b;
    secp256k1_pkg::scalar_t   s;
    secp256k1_pkg::scalar_t   r;
    int e;
    e = total_errors();
    bp_en <= 1'b1;
    repeat (4) begin
      idx_a = rand64();
      s = ($urandom % 2 == 0) ? below_n() : above_n();
      r = ($urandom % 2 == 0) ? below_n() : above_n();
      st_a = expect_status(s, r, 1'b0);
      load_verify(idx_a, s, r);
      send_cmd(sig_cmd_pkg::CMD_BEATS, -1, 0);
      idx_b = rand64();
      s = ($urandom % 2 == 0) ? below_n() : above_n();
      r = ($urandom % 2 == 0) ? below_n() : above_n();
      st_b = expect_status(s, r, 1'b0);
      load_verify(idx_b, s, r);
      send_cmd(sig_cmd_pkg::CMD_BEATS, -1, 0);
      check_reply(idx_a, st_a, "back-pressure first");
      check_reply(idx_b, st_b, "back-pressure second");
    end
    bp_en <= 1'b0;
    expect_quiet(10);
    finish_test("reply back-pressure", e);
  endtask

  task automatic test_watchdog();
    sig_cmd_pkg::beat_dat_t idx;
    int e;
    e = total_errors();
    idx = rand64();
    load_verify(idx, above_n(), below_n());
    // Stall after the s words for longer than the watchdog limit
    send_cmd(sig_cmd_pkg::CMD_BEATS, R_BEAT, sig_cmd_pkg::WDOG_CYCLES + 64);
    check_reply(idx, expect_status('0, '0, 1'b1), "watchdog");
    expect_quiet(8);
    verify_once(below_n(), below_n());
    finish_test("watchdog", e);
  endtask

  initial begin
    i_rpl_rdy = 1'b1;
    forever begin
      @(posedge i_clk);
      if (bp_en) begin
        i_rpl_rdy <= (($urandom % 3) != 0);
      end else begin
        i_rpl_rdy <= 1'b1;
      end
    end
  end

  // Collects reply beats and checks that a stalled beat holds
  initial begin
    stalled = 1'b0;
    held_beat = '0;
    forever begin
      @(negedge i_clk);
      if (!i_rst) begin
        if (stalled) begin
          assert (o_rpl_val)
            else begin
              mon_err++;
              $display("Fail %0t o_rpl_val expected 1 got 0", $time);
            end
          assert (o_rpl == held_beat)
            else begin
              mon_err++;
              $display("Fail %0t o_rpl expected %h got %h", $time, held_beat, o_rpl);
            end
        end
        if (o_rpl_val && i_rpl_rdy) begin
          rpl_q.push_back(o_rpl);
        end
        stalled = o_rpl_val && !i_rpl_rdy;
        held_beat = o_rpl;
      end
    end
  end

  initial begin
    while (cycle_cnt < 4 * sig_cmd_pkg::WDOG_CYCLES + 40 * cmd_cnt) begin
      @(posedge i_clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish after %0d cycles", cycle_cnt);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    i_cmd = '0;
    i_cmd_val = 1'b0;
    bp_en = 1'b0;
    void'($urandom(32'hb28));
    @(negedge i_rst);
    test_valid();
    test_range();
    test_unknown();
    test_backpressure();
    test_watchdog();
    $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
